// File: runSim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module rvCoreTb -o VrvCoreTb -f vlog.f

./obj_dir/VrvCoreTb 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "runSim: failure reported in sim.log"
    exit 1
fi

if ! grep -q "Simulation completed successfully" sim.log; then
    echo "runSim: run ended without a result line"
    exit 1
fi

echo "runSim: passed"

// File: verification/rvCoreTb.sv
`default_nettype none

module rvCoreTb;

    localparam int ClkPeriod    = 40;
    localparam int ResetCycles  = 3;
    localparam int WordsPerTest = 8;   // instr alu chkAlu bt err pcAfter regIdx regVal
    localparam int MaxTests     = 64;
    localparam logic [31:0] EndMarker = 32'hFFFF_FFFF;  // instruction word closing the list

    logic        clk;
    logic        rstN;
    logic [31:0] instruction;
    logic        instrValid;
    logic [31:0] pc;
    logic [31:0] aluResult;
    logic        zeroFlag;
    logic        branchTaken;
    logic        errFlag;
    logic [31:0] regWindow [32];

    logic [31:0] vectors [WordsPerTest*MaxTests];  // flat word stream from the mem file
    logic [31:0] shadowRegs [32];                  // expected register contents
    logic [31:0] expPc;                            // expected pc after last commit
    int          numTests;
    int          limitCycles;                      // watchdog budget, 0 until known
    int          mismatches;
    int          otherErrors;

    rvCore #(
        .resetVector(32'h0000_0000)
    ) i_dut (
        .clk(clk), .rstN(rstN), .instruction(instruction), .instrValid(instrValid),
        .pc(pc), .aluResult(aluResult), .zeroFlag(zeroFlag),
        .branchTaken(branchTaken), .errFlag(errFlag), .regWindow(regWindow)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // pc and the whole register file against the expected state
    task automatic checkState(input string stage);
        if (pc !== expPc) begin
            $display("Mismatch at %0t: %s pc is %h, expected %h", $time, stage, pc, expPc);
            mismatches++;
        end
        for (int r = 0; r < 32; r++) begin
            if (regWindow[r] !== shadowRegs[r]) begin
                $display("Mismatch at %0t: %s x%0d is %h, expected %h",
                         $time, stage, r, regWindow[r], shadowRegs[r]);
                mismatches++;
            end
        end
    endtask

    // idle slots with junk on the bus, entered and left on a falling edge
    task automatic idleCycles(input int count);
        for (int c = 0; c < count; c++) begin
            instrValid  = 1'b0;
            instruction = $urandom;  // must be ignored
            #1;
            if (branchTaken !== 1'b0 || errFlag !== 1'b0) begin
                $display("Mismatch at %0t: idle flags branchTaken %b errFlag %b, expected 0",
                         $time, branchTaken, errFlag);
                mismatches++;
            end
            @(negedge clk);
            checkState("idle");  // nothing may have moved
        end
    endtask

    // one instruction: present, check same-cycle outputs, then the commit
    task automatic runTest(input int t);
        logic [31:0] instr;
        logic [31:0] expAlu;
        logic [31:0] chkAlu;
        logic [31:0] expBt;
        logic [31:0] expErr;
        logic [31:0] nextPc;
        logic [31:0] regIdx;
        logic [31:0] regVal;
        int          base;
        base   = t * WordsPerTest;
        instr  = vectors[base];
        expAlu = vectors[base + 1];
        chkAlu = vectors[base + 2];
        expBt  = vectors[base + 3];
        expErr = vectors[base + 4];
        nextPc = vectors[base + 5];
        regIdx = vectors[base + 6];
        regVal = vectors[base + 7];

        instruction = instr;
        instrValid  = 1'b1;
        #1;  // combinational outputs settled
        if (chkAlu[0] && aluResult !== expAlu) begin
            $display("Mismatch at %0t: test %0d (%h) aluResult %h, expected %h",
                     $time, t, instr, aluResult, expAlu);
            mismatches++;
        end
        if (chkAlu[0] && zeroFlag !== (expAlu == 32'h0000_0000)) begin
            $display("Mismatch at %0t: test %0d (%h) zeroFlag %b for result %h",
                     $time, t, instr, zeroFlag, expAlu);
            mismatches++;
        end
        if (branchTaken !== expBt[0]) begin
            $display("Mismatch at %0t: test %0d (%h) branchTaken %b, expected %b",
                     $time, t, instr, branchTaken, expBt[0]);
            mismatches++;
        end
        if (errFlag !== expErr[0]) begin
            $display("Mismatch at %0t: test %0d (%h) errFlag %b, expected %b",
                     $time, t, instr, errFlag, expErr[0]);
            mismatches++;
        end

        @(negedge clk);  // commit edge has passed
        instrValid = 1'b0;
        expPc      = nextPc;
        shadowRegs[regIdx[4:0]] = regVal;  // x0 lines carry zero
        checkState($sformatf("test %0d", t));
    endtask

    initial begin
        clk         = 1'b0;
        rstN        = 1'b0;
        instruction = 32'h0000_0000;
        instrValid  = 1'b0;
        mismatches  = 0;
        otherErrors = 0;
        numTests    = 0;
        limitCycles = 0;
        expPc       = 32'h0000_0000;  // resetVector
        for (int r = 0; r < 32; r++) begin
            shadowRegs[r] = 32'h0000_0000;
        end
        void'($urandom(32'h7470));

        $readmemh("verification/rvCoreTests.mem", vectors);
        while (numTests < MaxTests && vectors[numTests * WordsPerTest] !== EndMarker) begin
            numTests++;
        end
        if (numTests == MaxTests || numTests == 0) begin
            $display("Error: test vector file is missing, empty or has no end marker");
            otherErrors++;
            numTests = 0;
        end
        limitCycles = numTests * 5 + ResetCycles;

        repeat (ResetCycles) @(negedge clk);
        rstN = 1'b1;
        checkState("after reset");
        idleCycles(1 + $urandom % 3);  // at least one idle slot before the program

        for (int t = 0; t < numTests; t++) begin
            runTest(t);
            idleCycles($urandom % 4);
        end

        $display("Checks done: %0d tests, %0d mismatches, %0d other errors",
                 numTests, mismatches, otherErrors);
        if (mismatches == 0 && otherErrors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog, budget known once the vectors are counted
    initial begin
        wait (limitCycles != 0);
        repeat (limitCycles + 10) @(posedge clk);  // small margin past the last step
        $display("Timeout: run did not finish within %0d clock cycles", limitCycles + 10);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/rvCoreTests.mem
// columns: instruction aluResult checkAlu branchTaken errFlag pcAfter regIndex regValue
// checkAlu 0 leaves aluResult and zeroFlag unchecked, last line ffffffff ends the list
00500093 00000005 1 0 0 00000004 01 00000005  // addi x1, x0, 5
ffd00113 fffffffd 1 0 0 00000008 02 fffffffd  // addi x2, x0, -3
002081b3 00000002 1 0 0 0000000c 03 00000002  // add  x3, x1, x2
40110233 fffffff8 1 0 0 00000010 04 fffffff8  // sub  x4, x2, x1
401082b3 00000000 1 0 0 00000014 05 00000000  // sub  x5, x1, x1 zero result
40125333 ffffffff 1 0 0 00000018 06 ffffffff  // sra  x6, x4, x1
001253b3 07ffffff 1 0 0 0000001c 07 07ffffff  // srl  x7, x4, x1
00122433 00000001 1 0 0 00000020 08 00000001  // slt  x8, x4, x1 signed
001234b3 00000000 1 0 0 00000024 09 00000000  // sltu x9, x4, x1 unsigned
fff22513 00000001 1 0 0 00000028 0a 00000001  // slti x10, x4, -1
fff0b593 00000001 1 0 0 0000002c 0b 00000001  // sltiu x11, x1, -1
00409613 00000050 1 0 0 00000030 0c 00000050  // slli x12, x1, 4
40225693 fffffffe 1 0 0 00000034 0d fffffffe  // srai x13, x4, 2
0ff14713 ffffff02 1 0 0 00000038 0e ffffff02  // xori x14, x2, 0xff
00c0e7b3 00000055 1 0 0 0000003c 0f 00000055  // or   x15, x1, x12
00f7f813 00000005 1 0 0 00000040 10 00000005  // andi x16, x15, 0xf
001098b3 000000a0 1 0 0 00000044 11 000000a0  // sll  x17, x1, x1
12345937 00000000 0 0 0 00000048 12 12345000  // lui  x18, 0x12345
00001997 00001048 1 0 0 0000004c 13 00001048  // auipc x19, 0x1
abcde037 00000000 0 0 0 00000050 00 00000000  // lui  x0, 0xabcde stays zero
01000a6f 00000000 0 0 0 00000060 14 00000054  // jal  x20, +16
07008ae7 00000075 1 0 0 00000074 15 00000064  // jalr x21, 0x70(x1) bit 0 cleared
01008463 00000000 0 1 0 0000007c 01 00000005  // beq  x1, x16 taken
00408463 00000000 0 0 0 00000080 01 00000005  // beq  x1, x4 not taken
00409463 00000000 0 1 0 00000088 01 00000005  // bne  x1, x4 taken
01009463 00000000 0 0 0 0000008c 01 00000005  // bne  x1, x16 not taken
00124663 00000000 0 1 0 00000098 01 00000005  // blt  x4, x1 taken
0040c663 00000000 0 0 0 0000009c 01 00000005  // blt  x1, x4 not taken
0040d463 00000000 0 1 0 000000a4 01 00000005  // bge  x1, x4 taken
00125463 00000000 0 0 0 000000a8 01 00000005  // bge  x4, x1 not taken
0040e463 00000000 0 1 0 000000b0 01 00000005  // bltu x1, x4 taken
00126463 00000000 0 0 0 000000b4 01 00000005  // bltu x4, x1 not taken
fe127ce3 00000000 0 1 0 000000ac 01 00000005  // bgeu x4, x1 taken backward
0040f463 00000000 0 0 0 000000b0 01 00000005  // bgeu x1, x4 not taken
0000a283 00000000 0 0 1 000000b4 05 00000000  // lw, load opcode illegal
02108333 00000000 0 0 1 000000b8 06 ffffffff  // mul, bad funct7
0000a063 00000000 0 0 1 000000bc 01 00000005  // branch funct3 2
40409393 00000000 0 0 1 000000c0 07 07ffffff  // slli with funct7 0100000
00108033 0000000a 1 0 0 000000c4 00 00000000  // add  x0, x1, x1 dropped
00000b13 00000000 1 0 0 000000c8 16 00000000  // addi x22, x0, 0
ffffffff 00000000 0 0 0 00000000 00 00000000  // end of list

// File: verilog/controlUnit.sv
`default_nettype none

module controlUnit
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
(
    input  rvOpcodeE    opcode,
    input  logic [2:0]  funct3,
    input  logic [6:0]  funct7,
    input  logic        instrValid,  // instruction present this cycle
    output aluOpE       aluOp,
    output branchCondE  branchCond,
    output opASrcE      opASrc,
    output logic        useImm,      // operand b from immediate
    output wbSrcE       wbSrc,
    output logic        regWrite,    // gated write enable
    output logic        isBranch,    // gated conditional branch
    output logic        isJump,      // gated jal/jalr
    output logic        isJalr,
    output logic        illegal      // unsupported encoding, while valid
);

    logic  altF7;     // funct7 selects sub/sra
    logic  badInstr;  // raw decode error
    logic  writesRd;
    logic  branchOp;
    logic  jumpOp;
    aluOpE arithOp;   // alu op from funct3/funct7

    assign altF7 = (funct7 == f7Alt);

    // arithmetic mapping, sub only for register form
    always_comb begin
        case (funct3)
            f3Add:   arithOp = (altF7 && opcode == opReg) ? aluSub : aluAdd;
            f3Sll:   arithOp = aluSll;
            f3Slt:   arithOp = aluSlt;
            f3Sltu:  arithOp = aluSltu;
            f3Xor:   arithOp = aluXor;
            f3Srl:   arithOp = altF7 ? aluSra : aluSrl;  // srai uses imm[11:5]
            f3Or:    arithOp = aluOr;
            default: arithOp = aluAnd;
        endcase
    end

    always_comb begin
        aluOp      = aluAdd;
        branchCond = bcEq;
        opASrc     = opAReg;
        useImm     = 1'b0;
        wbSrc      = wbAlu;
        writesRd   = 1'b0;
        branchOp   = 1'b0;
        jumpOp     = 1'b0;
        isJalr     = 1'b0;
        badInstr   = 1'b0;
        case (opcode)
            opReg: begin
                aluOp    = arithOp;
                writesRd = 1'b1;
                // alt funct7 only legal on add and srl
                badInstr = !(funct7 == f7Base ||
                             (altF7 && (funct3 == f3Add || funct3 == f3Srl)));
            end
            opImm: begin
                aluOp    = arithOp;
                useImm   = 1'b1;
                writesRd = 1'b1;
                if (funct3 == f3Sll) begin
                    badInstr = (funct7 != f7Base);
                end else if (funct3 == f3Srl) begin
                    badInstr = !(funct7 == f7Base || altF7);
                end
            end
            opLui: begin
                wbSrc    = wbImm;  // imm straight to rd
                useImm   = 1'b1;
                writesRd = 1'b1;
            end
            opAuipc: begin
                opASrc   = opAPc;  // pc + imm
                useImm   = 1'b1;
                writesRd = 1'b1;
            end
            opJal: begin
                opASrc   = opAPc;  // alu shows the target
                useImm   = 1'b1;
                wbSrc    = wbLink;
                writesRd = 1'b1;
                jumpOp   = 1'b1;
            end
            opJalr: begin
                useImm   = 1'b1;   // rs1 + imm
                wbSrc    = wbLink;
                writesRd = 1'b1;
                jumpOp   = 1'b1;
                isJalr   = 1'b1;
            end
            opBranch: begin
                aluOp    = aluSub; // rs1 - rs2, zero on equal
                branchOp = 1'b1;
                case (funct3)
                    f3Beq:   branchCond = bcEq;
                    f3Bne:   branchCond = bcNe;
                    f3Blt:   branchCond = bcLt;
                    f3Bge:   branchCond = bcGe;
                    f3Bltu:  branchCond = bcLtu;
                    f3Bgeu:  branchCond = bcGeu;
                    default: badInstr   = 1'b1;  // funct3 2 and 3
                endcase
            end
            default: badInstr = 1'b1;  // loads, stores, system, ...
        endcase
    end

    // nothing commits from an idle or bad slot
    assign illegal  = badInstr && instrValid;
    assign regWrite = writesRd && instrValid && !badInstr;
    assign isBranch = branchOp && instrValid && !badInstr;
    assign isJump   = jumpOp && instrValid && !badInstr;

endmodule

`default_nettype wire

// File: verilog/executeUnit.sv
`default_nettype none

module executeUnit
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
(
    input  logic [31:0] rdData1,     // rs1 value
    input  logic [31:0] rdData2,     // rs2 value
    input  logic [31:0] pc,          // current instruction address
    input  logic [31:0] imm,
    input  opASrcE      opASrc,
    input  logic        useImm,
    input  aluOpE       aluOp,
    input  branchCondE  branchCond,
    output logic [31:0] aluResult,
    output logic        zeroFlag,    // aluResult == 0
    output logic        condTrue     // branch condition holds
);

    logic [31:0] opA;
    logic [31:0] opB;
    logic [4:0]  shamt;      // shift amount, low 5 bits of b
    logic        lessS;      // signed rs1 < rs2
    logic        lessU;      // unsigned rs1 < rs2
    logic        regsEqual;

    assign opA   = (opASrc == opAPc) ? pc : rdData1;
    assign opB   = useImm ? imm : rdData2;
    assign shamt = opB[4:0];

    always_comb begin
        case (aluOp)
            aluAdd:  aluResult = opA + opB;
            aluSub:  aluResult = opA - opB;
            aluSll:  aluResult = opA << shamt;
            aluSlt:  aluResult = {31'd0, $signed(opA) < $signed(opB)};
            aluSltu: aluResult = {31'd0, opA < opB};
            aluXor:  aluResult = opA ^ opB;
            aluSrl:  aluResult = opA >> shamt;
            aluSra:  aluResult = $unsigned($signed(opA) >>> shamt);  // keeps sign
            aluOr:   aluResult = opA | opB;
            aluAnd:  aluResult = opA & opB;
            default: aluResult = 32'h0000_0000;
        endcase
    end

    assign zeroFlag = (aluResult == 32'h0000_0000);

    // branch compare always on the two registers
    assign regsEqual = (rdData1 == rdData2);
    assign lessS     = $signed(rdData1) < $signed(rdData2);
    assign lessU     = rdData1 < rdData2;

    always_comb begin
        case (branchCond)
            bcEq:    condTrue = regsEqual;
            bcNe:    condTrue = !regsEqual;
            bcLt:    condTrue = lessS;
            bcGe:    condTrue = !lessS;
            bcLtu:   condTrue = lessU;
            bcGeu:   condTrue = !lessU;
            default: condTrue = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/instrDecode.sv
`default_nettype none

module instrDecode
    import rvIsaPkg::*;
(
    input  logic [31:0] instruction,  // raw instruction word
    output logic [4:0]  rs1,          // source reg 1
    output logic [4:0]  rs2,          // source reg 2
    output logic [4:0]  rd,           // dest reg
    output rvOpcodeE    opcode,       // major opcode
    output logic [2:0]  funct3,
    output logic [6:0]  funct7,
    output logic [31:0] imm           // sign-extended immediate
);

    logic [31:0] immI;  // jalr, op-imm
    logic [31:0] immB;  // branches
    logic [31:0] immU;  // lui, auipc
    logic [31:0] immJ;  // jal

    // fixed field positions
    assign opcode = rvOpcodeE'(instruction[6:0]);
    assign rd     = instruction[11:7];
    assign funct3 = instruction[14:12];
    assign rs1    = instruction[19:15];
    assign rs2    = instruction[24:20];
    assign funct7 = instruction[31:25];

    assign immI = {{20{instruction[31]}}, instruction[31:20]};
    assign immB = {{19{instruction[31]}}, instruction[31], instruction[7],
                   instruction[30:25], instruction[11:8], 1'b0};  // lsb always 0
    assign immU = {instruction[31:12], 12'h000};
    assign immJ = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                   instruction[20], instruction[30:21], 1'b0};  // lsb always 0

    // format picked by opcode
    always_comb begin
        case (opcode)
            opImm, opJalr:   imm = immI;
            opBranch:        imm = immB;
            opLui, opAuipc:  imm = immU;
            opJal:           imm = immJ;
            opReg:           imm = 32'h0000_0000;  // no immediate
            default:         imm = immI;           // illegal op, value unused
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/pcUnit.sv
`default_nettype none

module pcUnit #(
    parameter logic [31:0] resetVector = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        instrValid,   // instruction taken this edge
    input  logic        isBranch,
    input  logic        condTrue,
    input  logic        isJump,
    input  logic        isJalr,
    input  logic [31:0] imm,
    input  logic [31:0] aluResult,    // rs1 + imm for jalr
    output logic [31:0] pc,
    output logic [31:0] linkAddr,     // return address
    output logic        branchTaken
);

    logic [31:0] nextPc;

    assign linkAddr    = pc + 32'd4;
    assign branchTaken = isBranch && condTrue;  // isBranch is low when idle

    always_comb begin
        if (isJump && isJalr) begin
            nextPc = {aluResult[31:1], 1'b0};  // clear bit 0
        end else if (isJump || branchTaken) begin
            nextPc = pc + imm;
        end else begin
            nextPc = linkAddr;  // sequential, also illegal
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= resetVector;
        end else if (instrValid) begin  // hold on idle
            pc <= nextPc;
        end
    end

    aPcAligned: assert property (@(posedge clk) disable iff (!rstN)
        instrValid |-> pc[1:0] == 2'b00)
        else $error("misaligned pc %h", pc);

endmodule

`default_nettype wire

// File: verilog/registerFile.sv
`default_nettype none

module registerFile
    import rvCtrlPkg::*;
(
    input  logic        clk,
    input  logic        rstN,           // async, active low
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        regWrite,       // already gated by valid/illegal
    input  wbSrcE       wbSrc,
    input  logic [31:0] aluResult,
    input  logic [31:0] imm,
    input  logic [31:0] linkAddr,       // pc + 4
    output logic [31:0] rdData1,
    output logic [31:0] rdData2,
    output logic [31:0] regWindow [32]  // full view for the testbench
);

    logic [31:0] regs [1:31];  // x0 not stored
    logic [31:0] wrData;

    always_comb begin
        case (wbSrc)
            wbImm:   wrData = imm;
            wbLink:  wrData = linkAddr;
            default: wrData = aluResult;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'h0000_0000;
            end
        end else if (regWrite && rd != 5'd0) begin  // writes to x0 dropped
            regs[rd] <= wrData;
        end
    end

    // combinational reads, x0 hard zero
    assign rdData1 = (rs1 == 5'd0) ? 32'h0000_0000 : regs[rs1];
    assign rdData2 = (rs2 == 5'd0) ? 32'h0000_0000 : regs[rs2];

    assign regWindow[0] = 32'h0000_0000;
    for (genvar g = 1; g < 32; g++) begin : gWindow
        assign regWindow[g] = regs[g];
    end

    aWbSrcLegal: assert property (@(posedge clk) disable iff (!rstN)
        regWrite |-> wbSrc inside {wbAlu, wbImm, wbLink})
        else $error("write with unknown writeback source %0d", wbSrc);

endmodule

`default_nettype wire

// File: verilog/rvCore.sv
`default_nettype none

module rvCore
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
#(
    parameter logic [31:0] resetVector = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] instruction,    // word at pc
    input  logic        instrValid,     // low inserts an idle cycle
    output logic [31:0] pc,
    output logic [31:0] aluResult,
    output logic        zeroFlag,
    output logic        branchTaken,
    output logic        errFlag,        // illegal instruction seen
    output logic [31:0] regWindow [32]
);

    // decode fields
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    rvOpcodeE    opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm;

    // controls
    aluOpE       aluOp;
    branchCondE  branchCond;
    opASrcE      opASrc;
    logic        useImm;
    wbSrcE       wbSrc;
    logic        regWrite;
    logic        isBranch;
    logic        isJump;
    logic        isJalr;

    // datapath
    logic [31:0] rdData1;
    logic [31:0] rdData2;
    logic        condTrue;
    logic [31:0] linkAddr;

    instrDecode i_decode (
        .instruction(instruction), .rs1(rs1), .rs2(rs2), .rd(rd),
        .opcode(opcode), .funct3(funct3), .funct7(funct7), .imm(imm)
    );

    controlUnit i_ctrl (
        .opcode(opcode), .funct3(funct3), .funct7(funct7), .instrValid(instrValid),
        .aluOp(aluOp), .branchCond(branchCond), .opASrc(opASrc), .useImm(useImm),
        .wbSrc(wbSrc), .regWrite(regWrite), .isBranch(isBranch), .isJump(isJump),
        .isJalr(isJalr), .illegal(errFlag)  // already qualified by instrValid
    );

    registerFile i_regs (
        .clk(clk), .rstN(rstN), .rs1(rs1), .rs2(rs2), .rd(rd),
        .regWrite(regWrite), .wbSrc(wbSrc), .aluResult(aluResult), .imm(imm),
        .linkAddr(linkAddr), .rdData1(rdData1), .rdData2(rdData2),
        .regWindow(regWindow)
    );

    executeUnit i_exec (
        .rdData1(rdData1), .rdData2(rdData2), .pc(pc), .imm(imm),
        .opASrc(opASrc), .useImm(useImm), .aluOp(aluOp), .branchCond(branchCond),
        .aluResult(aluResult), .zeroFlag(zeroFlag), .condTrue(condTrue)
    );

    pcUnit #(
        .resetVector(resetVector)
    ) i_pc (
        .clk(clk), .rstN(rstN), .instrValid(instrValid), .isBranch(isBranch),
        .condTrue(condTrue), .isJump(isJump), .isJalr(isJalr), .imm(imm),
        .aluResult(aluResult), .pc(pc), .linkAddr(linkAddr),
        .branchTaken(branchTaken)
    );

endmodule

`default_nettype wire

// File: verilog/rvCtrlPkg.sv
`default_nettype none

package rvCtrlPkg;

    // what lands in rd on writeback
    typedef enum logic [1:0] {
        wbAlu  = 2'd0,  // alu result
        wbImm  = 2'd1,  // lui immediate
        wbLink = 2'd2   // pc + 4 for jal/jalr
    } wbSrcE;

    // first alu operand
    typedef enum logic {
        opAReg = 1'b0,  // rs1 data
        opAPc  = 1'b1   // current pc, auipc and jal
    } opASrcE;

endpackage

`default_nettype wire

// File: verilog/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    // major opcodes kept by this core
    typedef enum logic [6:0] {
        opImm    = 7'b0010011,  // addi, slti, shifts, ...
        opReg    = 7'b0110011,  // add, sub, sll, ...
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011
    } rvOpcodeE;

    // funct3 for alu ops (reg and imm forms share these)
    localparam logic [2:0] f3Add  = 3'b000;  // add/sub/addi
    localparam logic [2:0] f3Sll  = 3'b001;
    localparam logic [2:0] f3Slt  = 3'b010;
    localparam logic [2:0] f3Sltu = 3'b011;
    localparam logic [2:0] f3Xor  = 3'b100;
    localparam logic [2:0] f3Srl  = 3'b101;  // srl/sra
    localparam logic [2:0] f3Or   = 3'b110;
    localparam logic [2:0] f3And  = 3'b111;

    // funct3 for branches
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Alt  = 7'b0100000;  // selects sub / sra

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu,
        aluXor, aluSrl, aluSra, aluOr, aluAnd
    } aluOpE;

    // encoded as the branch funct3 values
    typedef enum logic [2:0] {
        bcEq  = 3'b000,
        bcNe  = 3'b001,
        bcLt  = 3'b100,
        bcGe  = 3'b101,
        bcLtu = 3'b110,
        bcGeu = 3'b111
    } branchCondE;

endpackage

`default_nettype wire

// File: vlog.f
verilog/rvIsaPkg.sv
verilog/rvCtrlPkg.sv
verilog/instrDecode.sv
verilog/controlUnit.sv
verilog/executeUnit.sv
verilog/registerFile.sv
verilog/pcUnit.sv
verilog/rvCore.sv
verification/rvCoreTb.sv
